// ==== tempSensorPkg.sv ====
`default_nettype none

package tempSensorPkg;

    // Sequencing lengths in clk cycles
    localparam int PrechargeCycles = 16;
    localparam int DiodeCyclesBg = 9;
    localparam int DiodeCyclesPtat = 17;
    localparam int BigDiodeMaxCycles = 7;
    localparam int ChargeCycles = 6;
    localparam int MeasureCycles = 402;
    localparam int SleepCycles = 32;

    // Round limits
    localparam int BandgapRounds = 12;
    localparam int PtatMinRounds = 5;

    localparam int CountWidth = 8;
    localparam int CycleWidth = $clog2(MeasureCycles);
    localparam int RoundWidth = $clog2(BandgapRounds + 1);

    typedef logic [CountWidth-1:0] count_t;
    typedef logic [CycleWidth-1:0] cycleCount_t;
    typedef logic [RoundWidth-1:0] roundCount_t;

    typedef enum logic [1:0] {
        modeIdle,
        modeBandgap,
        modePtat
    } phaseMode_t;

    typedef enum logic [2:0] {
        msPrecharge,
        msBandgap,
        msPtat,
        msTempSens,
        msSleep
    } measureState_t;

    typedef enum logic [2:0] {
        psBlankDiode,
        psDiode,
        psBlankBigDiode,
        psBigDiode,
        psHCharge,
        psLCharge,
        psOutput
    } phaseState_t;

endpackage

`default_nettype wire

// ==== chopCounter.sv ====
`default_nettype none

module chopCounter (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp,
    input  logic                  measureEn,
    input  logic                  ptatSign,
    input  logic                  chopFsm,
    output tempSensorPkg::count_t tmpCount1,
    output tempSensorPkg::count_t tmpCount2,
    output logic                  cmpSync,
    output logic                  cmpP1,
    output logic                  cmpP2
);

    logic cmpMeta;
    logic cmpPrev;
    logic measureEnPrev;
    logic chopFlop;
    logic cmpRise;
    logic windowStart;

    // Two-flop synchronizer plus edge history
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            cmpMeta <= 1'b0;
            cmpSync <= 1'b0;
            cmpPrev <= 1'b0;
            measureEnPrev <= 1'b0;
        end else begin
            cmpMeta <= cmp;
            cmpSync <= cmpMeta;
            cmpPrev <= cmpSync;
            measureEnPrev <= measureEn;
        end
    end

    assign cmpRise = cmpSync & ~cmpPrev;
    assign windowStart = measureEn & ~measureEnPrev;

    // chopFlop holds the chopping offset relative to chopFsm, zero outside the window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            tmpCount1 <= '0;
            tmpCount2 <= '0;
            chopFlop <= 1'b0;
        end else if (windowStart) begin
            tmpCount1 <= '0;
            tmpCount2 <= '0;
            chopFlop <= 1'b0;
        end else if (!measureEn) begin
            chopFlop <= 1'b0;
        end else if (cmpRise) begin
            chopFlop <= ~chopFlop;
            if (ptatSign) begin
                tmpCount1 <= tmpCount1 + 1'b1;
            end else begin
                tmpCount2 <= tmpCount2 + 1'b1;
            end
        end
    end

    // No step on cmpP1 when the window opens
    assign cmpP1 = measureEn ? (chopFsm ^ chopFlop) : chopFsm;
    assign cmpP2 = ~cmpP1;

endmodule

`default_nettype wire

// ==== phaseSequencer.sv ====
`default_nettype none

module phaseSequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cmpSync,
    input  tempSensorPkg::phaseMode_t phaseMode,
    output logic                      pI1,
    output logic                      pI2,
    output logic                      pII1,
    output logic                      pII2,
    output logic                      pA,
    output logic                      pB,
    output logic                      pC,
    output logic                      pD,
    output logic                      srcN,
    output logic                      snk,
    output logic                      chopFsm,
    output logic                      roundDone,
    output logic                      diodeDone
);

    import tempSensorPkg::*;

    phaseState_t state;
    phaseState_t afterBlank;
    phaseMode_t  curMode;
    cycleCount_t count;
    cycleCount_t diodeLast;
    logic        capturedCmp;
    logic        hCharged;
    logic        active;
    logic        cmpHeld;
    logic        diodeEnd;
    logic        bigDiodeEnd;
    logic        chargeEnd;

    // Switches open as soon as the requested mode differs from the running one
    assign active = (curMode == phaseMode) && (curMode != modeIdle);

    assign diodeLast = (curMode == modePtat) ? cycleCount_t'(DiodeCyclesPtat - 1)
                                             : cycleCount_t'(DiodeCyclesBg - 1);
    assign diodeEnd = (state == psDiode) && (count == diodeLast);
    assign cmpHeld = (cmpSync == capturedCmp);
    // Bounded even if cmp never moves
    assign bigDiodeEnd = !cmpHeld || (count == cycleCount_t'(BigDiodeMaxCycles - 1));
    assign chargeEnd = (count == cycleCount_t'(ChargeCycles - 1));

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= psBlankBigDiode;
            afterBlank <= psDiode;
            curMode <= modeIdle;
            count <= '0;
            capturedCmp <= 1'b0;
            hCharged <= 1'b0;
            chopFsm <= 1'b1;
        end else if (phaseMode != curMode) begin
            // Restart on any mode change
            curMode <= phaseMode;
            state <= psBlankBigDiode;
            afterBlank <= psDiode;
            count <= '0;
            hCharged <= 1'b0;
        end else if (curMode != modeIdle) begin
            count <= count + 1'b1;
            case (state)
                psBlankBigDiode: begin
                    capturedCmp <= cmpSync;
                    state <= psBigDiode;
                    count <= '0;
                end
                psBigDiode: begin
                    if (bigDiodeEnd) begin
                        state <= psBlankDiode;
                        afterBlank <= psDiode;
                        count <= '0;
                    end
                end
                psBlankDiode: begin
                    state <= afterBlank;
                    count <= '0;
                end
                psDiode: begin
                    if (diodeEnd) begin
                        chopFsm <= ~chopFsm;
                        count <= '0;
                        if (curMode == modeBandgap) begin
                            state <= psBlankDiode;
                            afterBlank <= hCharged ? psLCharge : psHCharge;
                        end else begin
                            state <= psBlankBigDiode;
                        end
                    end
                end
                psHCharge: begin
                    if (chargeEnd) begin
                        hCharged <= 1'b1;
                        state <= psBlankBigDiode;
                        count <= '0;
                    end
                end
                psLCharge: begin
                    if (chargeEnd) begin
                        state <= psOutput;
                        count <= '0;
                    end
                end
                psOutput: begin
                    hCharged <= 1'b0;
                    state <= psBlankBigDiode;
                    count <= '0;
                end
                default: begin
                    state <= psBlankBigDiode;
                    count <= '0;
                end
            endcase
        end
    end

    // Switch decode, first switch of each pair closes during the blank cycle
    always_comb begin
        pI1 = 1'b0;
        pI2 = 1'b0;
        pII1 = 1'b0;
        pII2 = 1'b0;
        pA = 1'b0;
        pB = 1'b0;
        pC = 1'b0;
        pD = 1'b0;
        if (active) begin
            case (state)
                psBlankBigDiode: begin
                    pI1 = 1'b1;
                end
                psBigDiode: begin
                    pI1 = 1'b1;
                    pI2 = 1'b1;
                end
                psBlankDiode: begin
                    pII1 = (afterBlank == psDiode);
                end
                psDiode: begin
                    pII1 = 1'b1;
                    pII2 = 1'b1;
                end
                psHCharge: begin
                    pA = 1'b1;
                    pB = 1'b1;
                end
                psLCharge: begin
                    pA = 1'b1;
                    pC = 1'b1;
                end
                psOutput: begin
                    pB = 1'b1;
                    pC = 1'b1;
                    pD = 1'b1;
                end
                default: begin
                end
            endcase
        end
    end

    // Current drive while the comparator still agrees with its start value
    assign srcN = active && (state == psBigDiode) && cmpHeld && cmpSync;
    assign snk = active && (state == psBigDiode) && cmpHeld && !cmpSync;

    assign roundDone = active && (state == psOutput);
    assign diodeDone = active && diodeEnd;

endmodule

`default_nettype wire

// ==== measureSequencer.sv ====
`default_nettype none

module measureSequencer (
    input  logic                      clk,
    input  logic                      reset,
    input  logic                      cmpSync,
    input  logic                      roundDone,
    input  logic                      diodeDone,
    output tempSensorPkg::phaseMode_t phaseMode,
    output logic                      measureEn,
    output logic                      ptatSign,
    output logic                      preChrg,
    output logic                      pwrUp,
    output logic                      valid,
    output logic                      sBgCtrl,
    output logic                      sPtatCtrl,
    output logic                      sBg2Cmp,
    output logic                      sCap2Cmp,
    output logic                      sRef2Cmp,
    output logic                      sCapRst,
    output logic                      sPtatOut,
    output logic                      sRdisconN
);

    import tempSensorPkg::*;

    measureState_t state;
    measureState_t stateNext;
    cycleCount_t   cycleCount;
    roundCount_t   roundCount;
    logic          ptatAccept;

    // Sign change only counts after enough diode phases
    assign ptatAccept = diodeDone && (cmpSync != ptatSign)
                        && (roundCount >= roundCount_t'(PtatMinRounds - 1));

    always_comb begin
        stateNext = state;
        case (state)
            // Reset cycle sits here with outputs still low, hence no minus one
            msPrecharge: begin
                if (cycleCount == cycleCount_t'(PrechargeCycles)) begin
                    stateNext = msBandgap;
                end
            end
            msBandgap: begin
                if (roundDone && (roundCount == roundCount_t'(BandgapRounds - 1))) begin
                    stateNext = msPtat;
                end
            end
            msPtat: begin
                if (ptatAccept) begin
                    stateNext = msTempSens;
                end
            end
            msTempSens: begin
                if (cycleCount == cycleCount_t'(MeasureCycles - 1)) begin
                    stateNext = msSleep;
                end
            end
            msSleep: begin
                if (cycleCount == cycleCount_t'(SleepCycles - 1)) begin
                    stateNext = msBandgap;
                end
            end
            default: begin
                stateNext = msPrecharge;
            end
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            state <= msPrecharge;
            cycleCount <= '0;
            roundCount <= '0;
            ptatSign <= 1'b0;
        end else begin
            state <= stateNext;
            if (stateNext != state) begin
                cycleCount <= '0;
                roundCount <= '0;
            end else begin
                cycleCount <= cycleCount + 1'b1;
                if (state == msBandgap && roundDone) begin
                    roundCount <= roundCount + 1'b1;
                end else if (state == msPtat && diodeDone
                             && roundCount < roundCount_t'(PtatMinRounds - 1)) begin
                    roundCount <= roundCount + 1'b1;
                end
            end
            if (state == msPtat && ptatAccept) begin
                ptatSign <= cmpSync;
            end
        end
    end

    // Registered switch levels, decoded from the state being entered
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            phaseMode <= modeIdle;
            measureEn <= 1'b0;
            preChrg <= 1'b0;
            pwrUp <= 1'b0;
            valid <= 1'b0;
            sBgCtrl <= 1'b0;
            sPtatCtrl <= 1'b0;
            sBg2Cmp <= 1'b0;
            sCap2Cmp <= 1'b0;
            sRef2Cmp <= 1'b0;
            sCapRst <= 1'b0;
            sPtatOut <= 1'b0;
            sRdisconN <= 1'b0;
        end else begin
            phaseMode <= (stateNext == msBandgap) ? modeBandgap
                       : (stateNext == msPtat) ? modePtat : modeIdle;
            measureEn <= (stateNext == msTempSens);
            preChrg <= (stateNext == msPrecharge);
            pwrUp <= (stateNext != msSleep);
            valid <= (state == msTempSens) && (stateNext == msSleep);
            sBgCtrl <= (stateNext == msPrecharge) || (stateNext == msBandgap);
            sPtatCtrl <= (stateNext == msPrecharge) || (stateNext == msPtat)
                         || (stateNext == msTempSens);
            sBg2Cmp <= (stateNext == msBandgap) || (stateNext == msPtat);
            sCap2Cmp <= (stateNext == msTempSens);
            sRef2Cmp <= (stateNext == msTempSens);
            sCapRst <= (stateNext == msPrecharge) || (stateNext == msSleep);
            sPtatOut <= (stateNext == msTempSens);
            sRdisconN <= (stateNext == msPrecharge) || (stateNext == msBandgap)
                         || (stateNext == msSleep);
        end
    end

endmodule

`default_nettype wire

// ==== tempSensorTop.sv ====
`default_nettype none

module tempSensorTop (
    input  logic                  clk,
    input  logic                  reset,
    input  logic                  cmp,
    output logic                  pI1,
    output logic                  pI2,
    output logic                  pII1,
    output logic                  pII2,
    output logic                  pA,
    output logic                  pB,
    output logic                  pC,
    output logic                  pD,
    output logic                  srcN,
    output logic                  snk,
    output logic                  cmpP1,
    output logic                  cmpP2,
    output tempSensorPkg::count_t tmpCount1,
    output tempSensorPkg::count_t tmpCount2,
    output logic                  preChrg,
    output logic                  pwrUp,
    output logic                  valid,
    output logic                  sBgCtrl,
    output logic                  sPtatCtrl,
    output logic                  sBg2Cmp,
    output logic                  sCap2Cmp,
    output logic                  sRef2Cmp,
    output logic                  sCapRst,
    output logic                  sPtatOut,
    output logic                  sRdisconN
);

    import tempSensorPkg::*;

    phaseMode_t phaseMode;
    logic       cmpSync;
    logic       measureEn;
    logic       ptatSign;
    logic       chopFsm;
    logic       roundDone;
    logic       diodeDone;

    // Comparator sync and result counting
    chopCounter uChopCounter (
        .clk       (clk),
        .reset     (reset),
        .cmp       (cmp),
        .measureEn (measureEn),
        .ptatSign  (ptatSign),
        .chopFsm   (chopFsm),
        .tmpCount1 (tmpCount1),
        .tmpCount2 (tmpCount2),
        .cmpSync   (cmpSync),
        .cmpP1     (cmpP1),
        .cmpP2     (cmpP2)
    );

    phaseSequencer uPhaseSequencer (
        .clk       (clk),
        .reset     (reset),
        .cmpSync   (cmpSync),
        .phaseMode (phaseMode),
        .pI1       (pI1),
        .pI2       (pI2),
        .pII1      (pII1),
        .pII2      (pII2),
        .pA        (pA),
        .pB        (pB),
        .pC        (pC),
        .pD        (pD),
        .srcN      (srcN),
        .snk       (snk),
        .chopFsm   (chopFsm),
        .roundDone (roundDone),
        .diodeDone (diodeDone)
    );

    measureSequencer uMeasureSequencer (
        .clk       (clk),
        .reset     (reset),
        .cmpSync   (cmpSync),
        .roundDone (roundDone),
        .diodeDone (diodeDone),
        .phaseMode (phaseMode),
        .measureEn (measureEn),
        .ptatSign  (ptatSign),
        .preChrg   (preChrg),
        .pwrUp     (pwrUp),
        .valid     (valid),
        .sBgCtrl   (sBgCtrl),
        .sPtatCtrl (sPtatCtrl),
        .sBg2Cmp   (sBg2Cmp),
        .sCap2Cmp  (sCap2Cmp),
        .sRef2Cmp  (sRef2Cmp),
        .sCapRst   (sCapRst),
        .sPtatOut  (sPtatOut),
        .sRdisconN (sRdisconN)
    );

endmodule

`default_nettype wire

// ==== tempSensor_sva.sv ====
`default_nettype none

module tempSensor_sva (
    input logic                  clk,
    input logic                  reset,
    input logic                  pI2,
    input logic                  measureEn,
    input tempSensorPkg::count_t tmpCount1,
    input tempSensorPkg::count_t tmpCount2
);

    import tempSensorPkg::*;

    int bigDiodeLen;
    int windowLen;

    // Run lengths of the big-diode phase and of the window
    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            bigDiodeLen <= 0;
            windowLen <= 0;
        end else begin
            bigDiodeLen <= pI2 ? bigDiodeLen + 1 : 0;
            windowLen <= measureEn ? windowLen + 1 : 0;
        end
    end

    // Big diode ends even if cmp never moves
    bigDiodeBounded: assert property (@(posedge clk) disable iff (reset)
                                      bigDiodeLen <= BigDiodeMaxCycles)
        else $error("big-diode phase longer than its limit");

    windowLength: assert property (@(posedge clk) disable iff (reset)
                                   $fell(measureEn) |-> (windowLen == MeasureCycles))
        else $error("measurement window has the wrong length");

    countersCleared: assert property (@(posedge clk) disable iff (reset)
                                      $rose(measureEn) |=> (tmpCount1 == '0 && tmpCount2 == '0))
        else $error("result counters not cleared at window start");

endmodule

bind tempSensorTop tempSensor_sva sensorChecks (
    .clk       (clk),
    .reset     (reset),
    .pI2       (pI2),
    .measureEn (measureEn),
    .tmpCount1 (tmpCount1),
    .tmpCount2 (tmpCount2)
);

`default_nettype wire

// ==== tb_tempSensor.sv ====
`default_nettype none

module tb_tempSensor;

    import tempSensorPkg::*;

    localparam int MaxRounds = 32;
    localparam int PulseStart = 10;
    localparam logic [31:0] LfsrSeed = 32'h1bd2_0c18;

    logic   clk;
    logic   reset;
    logic   cmp;
    logic   pI1;
    logic   pI2;
    logic   pII1;
    logic   pII2;
    logic   pA;
    logic   pB;
    logic   pC;
    logic   pD;
    logic   srcN;
    logic   snk;
    logic   cmpP1;
    logic   cmpP2;
    count_t tmpCount1;
    count_t tmpCount2;
    logic   preChrg;
    logic   pwrUp;
    logic   valid;
    logic   sBgCtrl;
    logic   sPtatCtrl;
    logic   sBg2Cmp;
    logic   sCap2Cmp;
    logic   sRef2Cmp;
    logic   sCapRst;
    logic   sPtatOut;
    logic   sRdisconN;

    int patLevel [MaxRounds];
    int patCount [MaxRounds];
    int patHigh [MaxRounds];
    int patLow [MaxRounds];
    int numRounds;
    logic [31:0] lfsr;

    tempSensorTop dut (
        .clk       (clk),
        .reset     (reset),
        .cmp       (cmp),
        .pI1       (pI1),
        .pI2       (pI2),
        .pII1      (pII1),
        .pII2      (pII2),
        .pA        (pA),
        .pB        (pB),
        .pC        (pC),
        .pD        (pD),
        .srcN      (srcN),
        .snk       (snk),
        .cmpP1     (cmpP1),
        .cmpP2     (cmpP2),
        .tmpCount1 (tmpCount1),
        .tmpCount2 (tmpCount2),
        .preChrg   (preChrg),
        .pwrUp     (pwrUp),
        .valid     (valid),
        .sBgCtrl   (sBgCtrl),
        .sPtatCtrl (sPtatCtrl),
        .sBg2Cmp   (sBg2Cmp),
        .sCap2Cmp  (sCap2Cmp),
        .sRef2Cmp  (sRef2Cmp),
        .sCapRst   (sCapRst),
        .sPtatOut  (sPtatOut),
        .sRdisconN (sRdisconN)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // Galois form, taps 32 31 29 1
    function automatic logic [31:0] lfsrStep(input logic [31:0] state);
        return (state >> 1) ^ (state[0] ? 32'hD000_0001 : 32'h0);
    endfunction

    task automatic stopWithFailure(input string reason);
        $display("%s", reason);
        $display("Test FAILED");
        $fatal(1, "simulation stopped");
    endtask

    task automatic checkEq(input string name, input int actual, input int expected);
        if (actual != expected) begin
            stopWithFailure($sformatf("FAIL at %0t: %s = %0d, expected %0d",
                                      $time, name, actual, expected));
        end
    endtask

    task automatic checkResetState();
        logic [20:0] ctrl;
        ctrl = {pI1, pI2, pII1, pII2, pA, pB, pC, pD, srcN, snk, preChrg, pwrUp, valid,
                sBgCtrl, sPtatCtrl, sBg2Cmp, sCap2Cmp, sRef2Cmp, sCapRst, sPtatOut, sRdisconN};
        checkEq("control outputs", int'(ctrl), 0);
        checkEq("tmpCount1", int'(tmpCount1), 0);
        checkEq("tmpCount2", int'(tmpCount2), 0);
        checkEq("cmpP1", int'(cmpP1), 1);
        checkEq("cmpP2", int'(cmpP2), 0);
    endtask

    task automatic readPatterns();
        int fd;
        int n;
        int level;
        int count;
        int high;
        int low;
        string line;
        numRounds = 0;
        fd = $fopen("tempSensorPatterns.txt", "r");
        if (fd == 0) begin
            stopWithFailure("Could not open tempSensorPatterns.txt");
        end
        while (!$feof(fd) && numRounds < MaxRounds) begin
            line = "";
            if ($fgets(line, fd) != 0 && line.len() > 0 && line[0] != "#") begin
                n = $sscanf(line, "%d %d %d %d", level, count, high, low);
                if (n == 4) begin
                    // Pulses plus sync latency have to fit inside the window
                    if (high < 2 || low < 2
                        || PulseStart + count * (high + low) + 4 > MeasureCycles) begin
                        stopWithFailure("A pattern line does not fit the measurement window");
                    end
                    patLevel[numRounds] = level;
                    patCount[numRounds] = count;
                    patHigh[numRounds] = high;
                    patLow[numRounds] = low;
                    numRounds++;
                end
            end
        end
        $fclose(fd);
        if (numRounds == 0) begin
            stopWithFailure("The pattern file holds no measurement rounds");
        end
    endtask

    initial begin
        int   cycle;
        int   timeoutLimit;
        int   winLen;
        int   toggles;
        int   sleepLen;
        int   preLen;
        int   roundIdx;
        int   offset;
        int   period;
        logic prevCap;
        logic prevCmpP1;
        logic preDone;
        logic inSleep;
        logic closing;
        logic finished;

        reset = 1'b1;
        cmp = 1'b0;
        lfsr = LfsrSeed;
        readPatterns();
        timeoutLimit = numRounds * (MeasureCycles + SleepCycles + 2000);

        repeat (5) begin
            @(posedge clk);
            #2;
            checkResetState();
        end
        reset = 1'b0;
        #1;
        checkResetState();

        cycle = 0;
        winLen = 0;
        toggles = 0;
        sleepLen = 0;
        preLen = 0;
        roundIdx = 0;
        prevCap = 1'b0;
        prevCmpP1 = cmpP1;
        preDone = 1'b0;
        inSleep = 1'b0;
        finished = 1'b0;

        while (!finished) begin
            @(posedge clk);
            #2;
            cycle++;
            if (cycle > timeoutLimit) begin
                stopWithFailure("Timeout: the measurement rounds did not complete in time");
            end
            checkEq("cmpP2", int'(cmpP2), int'(!cmpP1));

            if (!preDone) begin
                if (preChrg) begin
                    preLen++;
                end else begin
                    checkEq("preChrg high cycles", preLen, PrechargeCycles);
                    preDone = 1'b1;
                end
            end else begin
                checkEq("preChrg", int'(preChrg), 0);
            end

            if (sCap2Cmp && !prevCap) begin
                if (roundIdx >= numRounds) begin
                    stopWithFailure("A measurement window opened after the last round");
                end
                winLen = 0;
                toggles = 0;
            end
            if (sCap2Cmp) begin
                winLen++;
            end
            if (sCap2Cmp && prevCap && (cmpP1 != prevCmpP1)) begin
                toggles++;
            end

            closing = prevCap && !sCap2Cmp;
            checkEq("valid", int'(valid), int'(closing));
            if (closing) begin
                checkEq("sCap2Cmp high cycles", winLen, MeasureCycles);
                checkEq("cmpP1 changes", toggles, patCount[roundIdx]);
                checkEq("tmpCount1", int'(tmpCount1),
                        (patLevel[roundIdx] != 0) ? patCount[roundIdx] : 0);
                checkEq("tmpCount2", int'(tmpCount2),
                        (patLevel[roundIdx] != 0) ? 0 : patCount[roundIdx]);
                roundIdx++;
                inSleep = 1'b1;
                sleepLen = 0;
            end

            if (inSleep) begin
                if (!pwrUp) begin
                    sleepLen++;
                end else begin
                    checkEq("pwrUp low cycles", sleepLen, SleepCycles);
                    inSleep = 1'b0;
                    finished = (roundIdx == numRounds);
                end
            end

            prevCap = sCap2Cmp;
            prevCmpP1 = cmpP1;

            // Pulse train inside the window, round level in PTAT, noise elsewhere
            if (sCap2Cmp) begin
                period = patHigh[roundIdx] + patLow[roundIdx];
                offset = winLen - PulseStart;
                if (offset >= 0 && offset < patCount[roundIdx] * period) begin
                    cmp = ((offset % period) < patHigh[roundIdx]);
                end else begin
                    cmp = 1'b0;
                end
            end else if (sPtatCtrl && sBg2Cmp && roundIdx < numRounds) begin
                cmp = (patLevel[roundIdx] != 0);
            end else begin
                cmp = lfsr[0];
                lfsr = lfsrStep(lfsr);
            end
        end

        $display("Test OK");
        $finish;
    end

endmodule

`default_nettype wire

// ==== tempSensorPatterns.txt ====
# ptatLevel pulseCount highWidth lowWidth
# one measurement round per line, pulse widths in clk cycles
1 5 2 2
0 12 3 4
1 0 2 2
0 40 4 3
1 90 2 2
0 1 2 5
1 25 6 6
0 60 3 3

// ==== project.f ====
tempSensorPkg.sv
chopCounter.sv
phaseSequencer.sv
measureSequencer.sv
tempSensorTop.sv
tempSensor_sva.sv
tb_tempSensor.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" &&
verilator --binary --timing --assert -Wno-fatal --top-module tb_tempSensor \
    -f project.f -o simv &&
./obj_dir/simv | tee /dev/stderr | grep -x "Test OK" > /dev/null &&
echo "Simulation passed" ||
{ echo "Simulation failed"; exit 1; }
